// ==== pipeCore.f ====
logic/isaPkg.sv
logic/busPkg.sv
logic/idExIf.sv
logic/apbDebug.sv
logic/instrFetch.sv
logic/instrDecode.sv
logic/aluUnit.sv
logic/branchUnit.sv
logic/writeBack.sv
logic/pipeTop.sv
test/pipeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -f pipeCore.f --top-module pipeTb -o VpipeTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VpipeTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Test failures found" "$logFile"; then
	echo "Simulation reported failures"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulator exited with status $simStatus"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0

// ==== test/pipeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeTb;

	localparam int imemWords      = 64;
	localparam int minBody        = 8;
	localparam int maxBody        = 40;  // Body plus HALT fits the memory
	localparam int numAluProgs    = 5;
	localparam int numBranchProgs = 6;
	localparam int numRuns        = numAluProgs + numBranchProgs + 3;  // Init and two error runs
	localparam int timeoutCycles  = numRuns * (imemWords * 4 + 200);
	localparam int pollLimit      = 200;
	localparam logic [31:0] rngSeed = 32'hb348fb74;

	logic             clk;
	logic             rst;
	logic             pSel;
	logic             pEnable;
	logic             pWrite;
	busPkg::apbAddr_t pAddr;
	isaPkg::word_t    pWData;
	isaPkg::word_t    pRData;
	logic             pReady;
	logic             pSlvErr;

	isaPkg::word_t    mRegs [32];  // Model register file
	isaPkg::word_t    prog [$];    // Current program image
	isaPkg::regIdx_t  lastDest;    // Feeds back-to-back dependences
	int               cycleCount;
	int unsigned      seedDummy;

	pipeTop #(.imemWords(imemWords)) dut_i (
		.clk(clk), .rst(rst), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr)
	);

	always #20 clk = ~clk;  // 40 ns period

	// Watchdog
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount == timeoutCycles) begin
			$display("Timeout, run still going after %0d cycles", timeoutCycles);
			abortRun();
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	task automatic abortRun();
		$display("Test failures found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkWord(input string name, input isaPkg::word_t got, input isaPkg::word_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkErr(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch pSlvErr on %s: got %h expected %h", what, got, exp);
			abortRun();
		end
	endtask

	//////////////////////////////////////////////////
	// APB host
	//////////////////////////////////////////////////
	// Entered and left 2 ns after a rising edge
	task automatic apbXfer(input logic write, input busPkg::apbAddr_t addr,
		input isaPkg::word_t wdata, output isaPkg::word_t rdata, output logic err);
		pSel    = 1'b1;  // Setup phase
		pEnable = 1'b0;
		pWrite  = write;
		pAddr   = addr;
		pWData  = wdata;
		@(posedge clk);
		#2;
		pEnable = 1'b1;  // Access phase
		@(negedge clk);  // Mid-cycle sample
		if (pReady !== 1'b1) begin
			$display("mismatch pReady at %h: got %h expected 1", addr, pReady);
			abortRun();
		end
		rdata = pRData;
		err   = pSlvErr;
		@(posedge clk);
		#2;
		pSel    = 1'b0;
		pEnable = 1'b0;
		pWrite  = 1'b0;
	endtask

	task automatic writeOk(input busPkg::apbAddr_t addr, input isaPkg::word_t data);
		isaPkg::word_t rdata;
		logic          err;
		apbXfer(1'b1, addr, data, rdata, err);
		checkErr($sformatf("write to %h", addr), err, 1'b0);
	endtask

	task automatic readOk(input busPkg::apbAddr_t addr, output isaPkg::word_t data);
		logic err;
		apbXfer(1'b0, addr, '0, data, err);
		checkErr($sformatf("read of %h", addr), err, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Program generation
	//////////////////////////////////////////////////
	function automatic isaPkg::regIdx_t pickSrc();
		if ($urandom_range(1, 0) == 1)
			return lastDest;  // Reuse the newest result
		return isaPkg::regIdx_t'($urandom_range(31, 0));
	endfunction

	function automatic isaPkg::word_t haltWord();
		isaPkg::instrWord_u w;
		w = '0;
		w.iFmt.opcode = isaPkg::opHalt;
		return w;
	endfunction

	function automatic isaPkg::word_t genAlu();
		isaPkg::instrWord_u w;
		isaPkg::regIdx_t    dest;
		int                 kind;
		w    = '0;
		dest = ($urandom_range(7, 0) == 0) ? 5'd0 : isaPkg::regIdx_t'($urandom_range(31, 1));
		kind = $urandom_range(8, 0);
		if (kind < 6) begin
			w.rFmt.opcode = isaPkg::opSpecial;
			w.rFmt.rs     = pickSrc();
			w.rFmt.rt     = pickSrc();
			w.rFmt.rd     = dest;
			case (kind)
				0:       w.rFmt.funct = isaPkg::fnAddu;
				1:       w.rFmt.funct = isaPkg::fnSubu;
				2:       w.rFmt.funct = isaPkg::fnAnd;
				3:       w.rFmt.funct = isaPkg::fnOr;
				4:       w.rFmt.funct = isaPkg::fnXor;
				default: w.rFmt.funct = isaPkg::fnSlt;
			endcase
		end else begin
			w.iFmt.rs    = pickSrc();
			w.iFmt.rt    = dest;
			w.iFmt.imm16 = 16'($urandom());
			case (kind)
				6:       w.iFmt.opcode = isaPkg::opAddiu;
				7:       w.iFmt.opcode = isaPkg::opOri;
				default: w.iFmt.opcode = isaPkg::opLui;
			endcase
		end
		if (dest != 5'd0)
			lastDest = dest;
		return w;
	endfunction

	// Forward target somewhere up to HALT
	function automatic isaPkg::word_t genBranch(input int idx, input int haltIdx);
		isaPkg::instrWord_u w;
		int                 target;
		int                 kind;
		w      = '0;
		target = $urandom_range(haltIdx, idx + 1);
		kind   = $urandom_range(2, 0);
		if (kind == 2) begin
			w.iFmt.opcode = isaPkg::opJal;
			{w.iFmt.rs, w.iFmt.rt, w.iFmt.imm16} = 26'(target);  // Word index into low memory
		end else begin
			if (kind == 0)
				w.iFmt.opcode = isaPkg::opBeq;
			else
				w.iFmt.opcode = isaPkg::opBne;
			w.iFmt.rs    = pickSrc();
			w.iFmt.rt    = ($urandom_range(1, 0) == 1) ? w.iFmt.rs : pickSrc();  // Often equal
			w.iFmt.imm16 = 16'(target - idx - 1);
		end
		return w;
	endfunction

	// ADDIU into every register so the model starts from known values
	task automatic buildInitProgram();
		isaPkg::instrWord_u w;
		int                 r;
		prog.delete();
		for (r = 1; r < 32; r++) begin
			w = '0;
			w.iFmt.opcode = isaPkg::opAddiu;
			w.iFmt.rt     = isaPkg::regIdx_t'(r);
			w.iFmt.imm16  = 16'($urandom());
			prog.push_back(w);
		end
		prog.push_back(haltWord());
		lastDest = 5'd31;
	endtask

	task automatic buildProgram(input bit withBranches, input int minLen);
		int bodyLen;
		int i;
		bodyLen = $urandom_range(maxBody, minLen);
		prog.delete();
		for (i = 0; i < bodyLen; i++) begin
			if (withBranches && $urandom_range(3, 0) == 0)
				prog.push_back(genBranch(i, bodyLen));
			else
				prog.push_back(genAlu());
		end
		prog.push_back(haltWord());
	endtask

	//////////////////////////////////////////////////
	// Instruction-set model
	//////////////////////////////////////////////////
	function automatic void setReg(input isaPkg::regIdx_t r, input isaPkg::word_t v);
		if (r != 5'd0)
			mRegs[r] = v;  // r0 is hardwired
	endfunction

	task automatic runModel(output int count);
		isaPkg::word_t      pc;
		isaPkg::word_t      pcNext;
		isaPkg::instrWord_u w;
		isaPkg::word_t      a;
		isaPkg::word_t      b;
		isaPkg::word_t      immS;
		int                 idx;
		bit                 stop;
		pc    = '0;
		count = 0;
		stop  = 1'b0;
		while (!stop) begin
			idx = int'(pc >> 2) % imemWords;
			if (count > 4 * imemWords || idx >= prog.size()) begin
				$display("Model left the program at pc %h without HALT", pc);
				abortRun();
			end
			w      = prog[idx];
			a      = mRegs[w.iFmt.rs];
			b      = mRegs[w.iFmt.rt];
			immS   = {{16{w.iFmt.imm16[15]}}, w.iFmt.imm16};
			pcNext = pc + 32'd4;
			count++;  // HALT counts too
			case (w.iFmt.opcode)
				isaPkg::opSpecial: begin
					case (w.rFmt.funct)
						isaPkg::fnAddu: setReg(w.rFmt.rd, a + b);
						isaPkg::fnSubu: setReg(w.rFmt.rd, a - b);
						isaPkg::fnAnd:  setReg(w.rFmt.rd, a & b);
						isaPkg::fnOr:   setReg(w.rFmt.rd, a | b);
						isaPkg::fnXor:  setReg(w.rFmt.rd, a ^ b);
						isaPkg::fnSlt:  setReg(w.rFmt.rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: ;
					endcase
				end
				isaPkg::opAddiu: setReg(w.iFmt.rt, a + immS);
				isaPkg::opOri:   setReg(w.iFmt.rt, a | {16'h0000, w.iFmt.imm16});
				isaPkg::opLui:   setReg(w.iFmt.rt, {w.iFmt.imm16, 16'h0000});
				isaPkg::opBeq: if (a == b) pcNext = pc + 32'd4 + {immS[29:0], 2'b00};
				isaPkg::opBne: if (a != b) pcNext = pc + 32'd4 + {immS[29:0], 2'b00};
				isaPkg::opJal: begin
					setReg(5'd31, pc + 32'd4);  // Return address without delay slot
					pcNext = {pcNext[31:28], w.iFmt.rs, w.iFmt.rt, w.iFmt.imm16, 2'b00};
				end
				isaPkg::opHalt: stop = 1'b1;
				default: ;
			endcase
			pc = pcNext;
		end
	endtask

	//////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////
	task automatic loadProgram();
		int i;
		for (i = 0; i < prog.size(); i++)
			writeOk(busPkg::imemBase + busPkg::apbAddr_t'(4 * i), prog[i]);
	endtask

	task automatic startCore();
		writeOk(busPkg::ctrlAddr, 32'h1 << busPkg::runBit);
	endtask

	task automatic waitHalt();
		isaPkg::word_t data;
		int            polls;
		polls = 0;
		data  = 32'h1 << busPkg::runBit;
		while (data[busPkg::runBit] == 1'b1) begin
			if (polls == pollLimit) begin
				$display("Core still running after %0d status polls", polls);
				abortRun();
			end
			readOk(busPkg::ctrlAddr, data);
			polls++;
		end
	endtask

	// Retired count and all registers against the model
	task automatic checkState(input int expCount);
		isaPkg::word_t data;
		int            r;
		readOk(busPkg::retiredAddr, data);
		checkWord("retired", data, isaPkg::word_t'(expCount));
		for (r = 0; r < 32; r++) begin
			readOk(busPkg::regBase + busPkg::apbAddr_t'(4 * r), data);
			checkWord($sformatf("r%0d", r), data, mRegs[isaPkg::regIdx_t'(r)]);
		end
	endtask

	task automatic executeProgram();
		int expCount;
		loadProgram();
		runModel(expCount);
		startCore();
		waitHalt();
		checkState(expCount);
	endtask

	task automatic errorAccesses();
		isaPkg::instrWord_u w;
		isaPkg::word_t      data;
		logic               err;
		int                 expCount;
		w = '0;
		w.iFmt.opcode = isaPkg::opAddiu;
		w.iFmt.rt     = 5'd5;
		w.iFmt.imm16  = 16'h5a5a;
		buildProgram(1'b0, 30);  // Long enough to still be running
		loadProgram();
		runModel(expCount);
		startCore();
		apbXfer(1'b1, busPkg::imemBase + 12'h004, w, data, err);
		checkErr("imem write while running", err, 1'b1);
		waitHalt();
		checkState(expCount);
		// Rerun of the same image shows the word was kept
		runModel(expCount);
		startCore();
		waitHalt();
		checkState(expCount);
		apbXfer(1'b1, busPkg::regBase + 12'h01c, 32'hdeadbeef, data, err);
		checkErr("register write", err, 1'b1);
		apbXfer(1'b1, busPkg::retiredAddr, 32'h0000ffff, data, err);
		checkErr("retired write", err, 1'b1);
		apbXfer(1'b0, 12'h300, '0, data, err);
		checkErr("unmapped read", err, 1'b1);
		apbXfer(1'b1, 12'h208, 32'h1, data, err);  // Next to ctrl and must not start the core
		checkErr("unmapped write", err, 1'b1);
		readOk(busPkg::ctrlAddr, data);
		checkWord("ctrl", data, 32'h1 << busPkg::doneBit);
		checkState(expCount);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		isaPkg::word_t data;
		int            p;
		clk        = 1'b0;
		rst        = 1'b1;
		pSel       = 1'b0;
		pEnable    = 1'b0;
		pWrite     = 1'b0;
		pAddr      = '0;
		pWData     = '0;
		cycleCount = 0;
		lastDest   = 5'd1;
		mRegs      = '{default: '0};
		seedDummy  = $urandom(rngSeed);
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		// Idle state after reset
		readOk(busPkg::ctrlAddr, data);
		checkWord("ctrl", data, '0);
		readOk(busPkg::retiredAddr, data);
		checkWord("retired", data, '0);

		buildInitProgram();
		executeProgram();
		for (p = 0; p < numAluProgs; p++) begin
			buildProgram(1'b0, minBody);
			executeProgram();
		end
		for (p = 0; p < numBranchProgs; p++) begin
			buildProgram(1'b1, minBody);
			executeProgram();
		end
		errorAccesses();

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/pipeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeTop #(
	parameter int imemWords = 64
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             pSel,
	input  logic             pEnable,
	input  logic             pWrite,
	input  busPkg::apbAddr_t pAddr,
	input  isaPkg::word_t    pWData,
	output isaPkg::word_t    pRData,
	output logic             pReady,
	output logic             pSlvErr
);
	//////////////////////////////////////////////////
	// Stage wiring
	//////////////////////////////////////////////////
	isaPkg::instrWord_u instr;       // fetch0 -> decode0
	isaPkg::word_t      pc;          // fetch0 -> decode0
	logic               fetchValid;  // fetch0 -> decode0
	logic               taken;       // branch0 -> fetch0 and decode0 flush
	isaPkg::word_t      target;      // branch0 -> fetch0
	isaPkg::word_t      linkAddr;    // branch0 -> wb0
	isaPkg::word_t      aluResult;   // alu0 -> wb0
	logic               halted;      // decode0 -> apb0
	logic               retire;      // wb0 -> apb0
	logic               wbWe;        // wb0 -> decode0
	isaPkg::regIdx_t    wbReg;       // wb0 -> decode0
	isaPkg::word_t      wbData;      // wb0 -> decode0
	isaPkg::regIdx_t    regIdx;      // apb0 -> decode0
	isaPkg::word_t      regData;     // decode0 -> apb0

	dbgIf #(.addrW($clog2(imemWords))) dbgBus ();
	idExIf idEx ();

	// Host port
	apbDebug #(.imemWords(imemWords)) apb0 (
		.clk(clk), .rst(rst),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr), .pWData(pWData),
		.halted(halted), .retire(retire),
		.pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
		.regIdx(regIdx), .regData(regData),
		.dbg(dbgBus)
	);

	// Fetch
	instrFetch #(.imemWords(imemWords)) fetch0 (
		.clk(clk), .rst(rst), .dbg(dbgBus),
		.taken(taken), .target(target),
		.instr(instr), .pc(pc), .fetchValid(fetchValid)
	);

	// Decode and register read
	instrDecode decode0 (
		.clk(clk), .rst(rst),
		.instr(instr), .pc(pc), .fetchValid(fetchValid), .flush(taken),
		.wbWe(wbWe), .wbReg(wbReg), .wbData(wbData),
		.regIdx(regIdx), .halted(halted), .regData(regData),
		.ex(idEx)
	);

	// Execute paths side by side
	aluUnit alu0 (.ex(idEx), .aluResult(aluResult));
	branchUnit branch0 (.ex(idEx), .taken(taken), .target(target), .linkAddr(linkAddr));

	writeBack wb0 (
		.clk(clk), .rst(rst),
		.aluResult(aluResult), .linkAddr(linkAddr), .wb(idEx),
		.wbWe(wbWe), .wbReg(wbReg), .wbData(wbData), .retire(retire)
	);

endmodule

`default_nettype wire

// ==== logic/writeBack.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeBack (
	input  logic            clk,
	input  logic            rst,
	input  isaPkg::word_t   aluResult,
	input  isaPkg::word_t   linkAddr,
	idExIf.wbStage          wb,
	output logic            wbWe,
	output isaPkg::regIdx_t wbReg,
	output isaPkg::word_t   wbData,
	output logic            retire
);

	// Control bits
	always_ff @(posedge clk) begin
		if (rst) begin
			wbWe   <= 1'b0;
			retire <= 1'b0;
		end else begin
			wbWe   <= wb.valid && wb.writeEn && wb.destReg != 5'd0;  // r0 stays 0
			retire <= wb.valid;  // Branches and HALT count too
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		wbReg  <= wb.destReg;
		wbData <= wb.isJal ? linkAddr : aluResult;  // Link for JAL
	end

endmodule

`default_nettype wire

// ==== logic/branchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
	idExIf.execute        ex,
	output logic          taken,
	output isaPkg::word_t target,
	output isaPkg::word_t linkAddr
);
	isaPkg::word_t pcPlus4;
	isaPkg::word_t brTarget;  // PC relative
	isaPkg::word_t jTarget;   // Pseudo-direct
	logic          sameVal;

	assign pcPlus4  = ex.pc + 32'd4;
	assign sameVal  = ex.operandA == ex.operandB;
	assign brTarget = pcPlus4 + {ex.imm32[29:0], 2'b00};
	assign jTarget  = {pcPlus4[31:28], ex.imm32[25:0], 2'b00};

	// BEQ on equal, BNE on not equal, JAL always
	assign taken  = ex.valid && (ex.isJal || (ex.isBranch && (sameVal != ex.branchNe)));
	assign target = ex.isJal ? jTarget : brTarget;

	assign linkAddr = pcPlus4;  // No delay slot

endmodule

`default_nettype wire

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	idExIf.execute        ex,
	output isaPkg::word_t aluResult
);
	isaPkg::word_t opB;  // Register or immediate
	logic          lessThan;

	assign opB      = ex.useImm ? ex.imm32 : ex.operandB;
	assign lessThan = $signed(ex.operandA) < $signed(opB);  // SLT is signed

	always_comb begin
		case (ex.aluOp)
			isaPkg::aluAdd: begin
				aluResult = ex.operandA + opB;  // ADDU and ADDIU, no overflow trap
			end
			isaPkg::aluSub: begin
				aluResult = ex.operandA - opB;
			end
			isaPkg::aluAnd: begin
				aluResult = ex.operandA & opB;
			end
			isaPkg::aluOr: begin
				aluResult = ex.operandA | opB;  // OR and ORI
			end
			isaPkg::aluXor: begin
				aluResult = ex.operandA ^ opB;
			end
			isaPkg::aluSlt: begin
				aluResult = {31'd0, lessThan};
			end
			isaPkg::aluLui: begin
				aluResult = {opB[15:0], 16'h0000};  // Upper half load
			end
			default: begin
				aluResult = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
	input  logic               clk,
	input  logic               rst,
	input  isaPkg::instrWord_u instr,
	input  isaPkg::word_t      pc,
	input  logic               fetchValid,
	input  logic               flush,       // Taken branch in execute
	input  logic               wbWe,
	input  isaPkg::regIdx_t    wbReg,
	input  isaPkg::word_t      wbData,
	input  isaPkg::regIdx_t    regIdx,      // Host read index
	output logic               halted,
	output isaPkg::word_t      regData,
	idExIf.source              ex
);
	isaPkg::word_t      regFile [32];
	isaPkg::instrWord_u idInstr;
	isaPkg::word_t      idPc;
	logic               idValid;
	isaPkg::word_t      rdA;
	isaPkg::word_t      rdB;
	isaPkg::word_t      immSext;
	isaPkg::word_t      immZext;
	isaPkg::regIdx_t    exRs;   // Kept for late forwarding
	isaPkg::regIdx_t    exRt;
	isaPkg::word_t      exOpA;
	isaPkg::word_t      exOpB;
	isaPkg::aluOp_e     dAluOp;
	logic               dUseImm;
	isaPkg::word_t      dImm;
	isaPkg::regIdx_t    dDest;
	logic               dWe;
	logic               dBr;
	logic               dBne;
	logic               dJal;

	// r0 reads 0, write-back data passes through
	function automatic isaPkg::word_t readPort(input isaPkg::regIdx_t idx);
		if (idx == 5'd0)
			return '0;
		else if (wbWe && wbReg == idx)
			return wbData;
		else
			return regFile[idx];
	endfunction

	//////////////////////////////////////////////////
	// IF/ID register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst)
			idValid <= 1'b0;
		else
			idValid <= fetchValid && !flush && !halted;  // Nothing behind HALT
	end

	always_ff @(posedge clk) begin
		idInstr <= instr;
		idPc    <= pc;
	end

	assign halted = idValid && !flush && idInstr.iFmt.opcode == isaPkg::opHalt;

	// Register file, three read ports
	always_ff @(posedge clk) begin
		if (wbWe)
			regFile[wbReg] <= wbData;
	end

	always_comb begin
		rdA     = readPort(idInstr.iFmt.rs);
		rdB     = readPort(idInstr.iFmt.rt);
		regData = readPort(regIdx);  // Host port
	end

	assign immSext = {{16{idInstr.iFmt.imm16[15]}}, idInstr.iFmt.imm16};
	assign immZext = {16'h0000, idInstr.iFmt.imm16};

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	always_comb begin
		dAluOp  = isaPkg::aluAdd;
		dUseImm = 1'b1;
		dImm    = immSext;
		dDest   = idInstr.iFmt.rt;  // I-type target
		dWe     = 1'b0;
		dBr     = 1'b0;
		dBne    = 1'b0;
		dJal    = 1'b0;
		case (idInstr.iFmt.opcode)
			isaPkg::opSpecial: begin
				dUseImm = 1'b0;
				dDest   = idInstr.rFmt.rd;
				dWe     = 1'b1;
				case (idInstr.rFmt.funct)
					isaPkg::fnAddu: dAluOp = isaPkg::aluAdd;
					isaPkg::fnSubu: dAluOp = isaPkg::aluSub;
					isaPkg::fnAnd:  dAluOp = isaPkg::aluAnd;
					isaPkg::fnOr:   dAluOp = isaPkg::aluOr;
					isaPkg::fnXor:  dAluOp = isaPkg::aluXor;
					isaPkg::fnSlt:  dAluOp = isaPkg::aluSlt;
					default:        dWe = 1'b0;  // Unknown funct is a no-op
				endcase
			end
			isaPkg::opAddiu: dWe = 1'b1;
			isaPkg::opOri: begin
				dAluOp = isaPkg::aluOr;
				dImm   = immZext;
				dWe    = 1'b1;
			end
			isaPkg::opLui: begin
				dAluOp = isaPkg::aluLui;
				dImm   = immZext;
				dWe    = 1'b1;
			end
			isaPkg::opBeq: dBr = 1'b1;
			isaPkg::opBne: begin
				dBr  = 1'b1;
				dBne = 1'b1;
			end
			isaPkg::opJal: begin
				dJal  = 1'b1;
				dWe   = 1'b1;
				dDest = 5'd31;  // Link register
				dImm  = {6'd0, idInstr.iFmt.rs, idInstr.iFmt.rt, idInstr.iFmt.imm16};
			end
			default: dWe = 1'b0;  // HALT and unknown opcodes
		endcase
	end

	//////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst)
			ex.valid <= 1'b0;
		else
			ex.valid <= idValid && !flush;
	end

	always_ff @(posedge clk) begin
		ex.aluOp    <= dAluOp;
		ex.useImm   <= dUseImm;
		ex.imm32    <= dImm;
		ex.pc       <= idPc;
		ex.destReg  <= dDest;
		ex.writeEn  <= dWe;
		ex.isBranch <= dBr;
		ex.branchNe <= dBne;
		ex.isJal    <= dJal;
		exOpA       <= rdA;
		exOpB       <= rdB;
		exRs        <= idInstr.iFmt.rs;
		exRt        <= idInstr.iFmt.rt;
	end

	// Result of the instruction just ahead sits in write-back
	assign ex.operandA = (wbWe && wbReg == exRs) ? wbData : exOpA;
	assign ex.operandB = (wbWe && wbReg == exRt) ? wbData : exOpB;

endmodule

`default_nettype wire

// ==== logic/instrFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrFetch #(
	parameter int imemWords = 64
) (
	input  logic               clk,
	input  logic               rst,
	dbgIf.sink                 dbg,
	input  logic               taken,
	input  isaPkg::word_t      target,
	output isaPkg::instrWord_u instr,
	output isaPkg::word_t      pc,
	output logic               fetchValid
);
	localparam int addrW = $clog2(imemWords);

	isaPkg::word_t    imem [imemWords];
	isaPkg::word_t    fetchPc;    // Next sequential address
	isaPkg::word_t    fetchAddr;  // Address read this cycle
	logic [addrW-1:0] memIdx;

	// Redirect wins over the sequential PC
	assign fetchAddr = taken ? target : fetchPc;
	assign memIdx    = fetchAddr[addrW+1:2];

	// Host load port
	always_ff @(posedge clk) begin
		if (dbg.imemWe)
			imem[dbg.imemAddr] <= dbg.imemData;
	end

	// Program counter and fetch valid
	always_ff @(posedge clk) begin
		if (rst || !dbg.run) begin
			fetchPc    <= '0;    // Idle core restarts at 0
			fetchValid <= 1'b0;  // Bubbles while stopped
		end else begin
			fetchPc    <= fetchAddr + 32'd4;
			fetchValid <= 1'b1;
		end
	end

	// Fetch register
	// Target word replaces the one in flight on a redirect
	always_ff @(posedge clk) begin
		instr <= imem[memIdx];
		pc    <= fetchAddr;
	end

endmodule

`default_nettype wire

// ==== logic/apbDebug.sv ====
`timescale 1ns/1ps
`default_nettype none

module apbDebug #(
	parameter int imemWords = 64
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             pSel,
	input  logic             pEnable,
	input  logic             pWrite,
	input  busPkg::apbAddr_t pAddr,
	input  isaPkg::word_t    pWData,
	input  logic             halted,
	input  logic             retire,
	output isaPkg::word_t    pRData,
	output logic             pReady,
	output logic             pSlvErr,
	output isaPkg::regIdx_t  regIdx,
	input  isaPkg::word_t    regData,
	dbgIf.source             dbg
);
	localparam int addrW = $clog2(imemWords);

	busPkg::apbAddr_t imemOff;
	busPkg::apbAddr_t regOff;
	logic             access;
	logic             inImem;
	logic             inReg;
	logic             isCtrl;
	logic             isRetired;
	logic             ctrlWrite;
	logic             runReg;
	logic             done;     // Latched HALT
	isaPkg::word_t    retired;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////
	assign access    = pSel && pEnable;  // Access phase only
	assign imemOff   = pAddr - busPkg::imemBase;
	assign regOff    = pAddr - busPkg::regBase;
	assign inImem    = imemOff < busPkg::apbAddr_t'(4 * imemWords);
	assign inReg     = regOff < busPkg::apbAddr_t'(4 * busPkg::regWords);
	assign isCtrl    = pAddr == busPkg::ctrlAddr;
	assign isRetired = pAddr == busPkg::retiredAddr;
	assign ctrlWrite = access && pWrite && isCtrl;

	assign pReady = 1'b1;  // No wait states
	// Unmapped, imem write while running, or write to a read-only word
	assign pSlvErr = access && (!(inImem || inReg || isCtrl || isRetired) ||
		(pWrite && ((inImem && runReg) || inReg || isRetired)));

	assign regIdx = regOff[6:2];

	// Instruction memory loads only while stopped
	assign dbg.imemWe   = access && pWrite && inImem && !runReg;
	assign dbg.imemAddr = imemOff[addrW+1:2];
	assign dbg.imemData = pWData;
	assign dbg.run      = runReg && !halted;  // Stop fetch on the HALT edge

	// Read mux
	always_comb begin
		pRData = '0;
		if (inReg) begin
			pRData = regData;
		end else if (isCtrl) begin
			pRData[busPkg::runBit]  = runReg;
			pRData[busPkg::doneBit] = done;
		end else if (isRetired) begin
			pRData = retired;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			runReg  <= 1'b0;
			done    <= 1'b0;
			retired <= '0;
		end else begin
			if (retire)
				retired <= retired + 32'd1;
			if (halted) begin
				runReg <= 1'b0;  // Hardware stop
				done   <= 1'b1;
			end
			if (ctrlWrite) begin
				runReg <= pWData[busPkg::runBit];
				if (pWData[busPkg::runBit]) begin
					retired <= '0;  // Fresh count per run
					done    <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/idExIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decoded operation held in the ID/EX register
interface idExIf;
	logic            valid;
	isaPkg::aluOp_e  aluOp;
	logic            useImm;    // Second ALU operand from imm32
	isaPkg::word_t   operandA;
	isaPkg::word_t   operandB;
	isaPkg::word_t   imm32;     // Extended immediate or jump index
	isaPkg::word_t   pc;
	isaPkg::regIdx_t destReg;
	logic            writeEn;
	logic            isBranch;
	logic            branchNe;  // BNE when set
	logic            isJal;

	modport source (output valid, aluOp, useImm, operandA, operandB, imm32, pc,
		destReg, writeEn, isBranch, branchNe, isJal);
	modport execute (input valid, aluOp, useImm, operandA, operandB, imm32, pc,
		isBranch, branchNe, isJal);
	modport wbStage (input valid, destReg, writeEn, isJal);
endinterface

// Host path into fetch
interface dbgIf #(
	parameter int addrW = 6
);
	logic             imemWe;
	logic [addrW-1:0] imemAddr;  // Word index
	isaPkg::word_t    imemData;
	logic             run;

	modport source (output imemWe, imemAddr, imemData, run);
	modport sink (input imemWe, imemAddr, imemData, run);
endinterface

`default_nettype wire

// ==== logic/busPkg.sv ====
`default_nettype none

package busPkg;

	typedef logic [11:0] apbAddr_t;  // Byte offset inside the slave window

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////
	localparam apbAddr_t imemBase    = 12'h000;  // Instruction words, write only
	localparam apbAddr_t regBase     = 12'h100;  // Architectural registers
	localparam apbAddr_t ctrlAddr    = 12'h200;  // Control and status
	localparam apbAddr_t retiredAddr = 12'h204;  // Retired instruction count

	localparam int regWords = 32;  // Words in the register window

	// Control and status bit positions
	localparam int runBit  = 0;  // Read/write
	localparam int doneBit = 1;  // Read only, set by HALT

endpackage

`default_nettype wire

// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

	typedef logic [31:0] word_t;    // Datapath word
	typedef logic [4:0]  regIdx_t;  // Register file index

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opSpecial = 6'b000000,  // R-type group
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opAddiu   = 6'b001001,
		opOri     = 6'b001101,
		opLui     = 6'b001111,
		opHalt    = 6'b111111   // Stops the core
	} opcode_e;

	// R-type function field
	typedef enum logic [5:0] {
		fnAddu = 6'b100001,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnSlt  = 6'b101010
	} funct_e;

	// ALU operation select from decode
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluLui
	} aluOp_e;

	typedef struct packed {
		opcode_e    opcode;
		regIdx_t    rs;
		regIdx_t    rt;
		regIdx_t    rd;
		logic [4:0] shamt;  // Unused here, no shifts
		funct_e     funct;
	} rType_s;

	typedef struct packed {
		opcode_e     opcode;
		regIdx_t     rs;
		regIdx_t     rt;
		logic [15:0] imm16;
	} iType_s;

	// One fetched word seen as either format
	typedef union packed {
		rType_s rFmt;
		iType_s iFmt;
	} instrWord_u;

endpackage

`default_nettype wire
